//--- hw/aes_pkg.sv
/*
 * AES datapath constants, the two-view state word and the
 * GF(2^8) multiply helpers used by MixColumns
 */

package aes_pkg;

  // ------------------------------
  // widths
  // ------------------------------
  localparam int BLOCK_W   = 128;
  localparam int WORD_W    = 32;
  localparam int BYTE_W    = 8;
  localparam int NUM_COLS  = 4;
  // round/key index, enough for 14 rounds
  localparam int KEY_IDX_W = 4;

  // ------------------------------
  // state word
  // ------------------------------
  // column 0 and byte 0 sit in the top bits
  // bytes are column-major, byte 4*c + r is row r of column c
  typedef union packed {
    logic [0:NUM_COLS-1][WORD_W-1:0]       cols;
    logic [0:BLOCK_W/BYTE_W-1][BYTE_W-1:0] bytes;
  } aes_state_t;

  // ------------------------------
  // GF(2^8) helpers
  // ------------------------------
  // multiply by x, reduce with 0x1b
  function automatic logic [BYTE_W-1:0] gm2(input logic [BYTE_W-1:0] op);
    logic [BYTE_W-1:0] shifted;
    shifted = {op[BYTE_W-2:0], 1'b0};
    return shifted ^ (8'h1b & {BYTE_W{op[BYTE_W-1]}});
  endfunction

  // multiply by x + 1
  function automatic logic [BYTE_W-1:0] gm3(input logic [BYTE_W-1:0] op);
    return gm2(op) ^ op;
  endfunction

endpackage

//--- hw/aes_round_if.sv
/*
 * one AES state in flight between two pipeline stages,
 * with its round key and final-round flag
 */

`timescale 1ns/1ps

interface aes_round_if import aes_pkg::*; ();

  // one-cycle strobe, the other fields only count while it is high
  logic               valid;
  aes_state_t         state;
  // final round, no MixColumns
  logic               last;
  logic [BLOCK_W-1:0] round_key;

  // producing stage
  modport src (
    output valid,
    output state,
    output last,
    output round_key
  );

  // consuming stage, captures in the valid cycle
  modport dst (
    input valid,
    input state,
    input last,
    input round_key
  );

endinterface

//--- hw/aes_sbox.sv
/*
 * AES forward S-box applied to all four bytes of a 32-bit word
 */

`timescale 1ns/1ps

module aes_sbox import aes_pkg::*; (
  input  logic [WORD_W-1:0] word,
  output logic [WORD_W-1:0] sub_word
);

  // ------------------------------
  // forward S-box table
  // ------------------------------
  // entry 0 in the top bits, one row of 16 per literal
  localparam logic [0:255][BYTE_W-1:0] SBOX = {
    128'h637c777bf26b6fc53001672bfed7ab76,
    128'hca82c97dfa5947f0add4a2af9ca472c0,
    128'hb7fd9326363ff7cc34a5e5f171d83115,
    128'h04c723c31896059a071280e2eb27b275,
    128'h09832c1a1b6e5aa0523bd6b329e32f84,
    128'h53d100ed20fcb15b6acbbe394a4c58cf,
    128'hd0efaafb434d338545f9027f503c9fa8,
    128'h51a3408f929d38f5bcb6da2110fff3d2,
    128'hcd0c13ec5f974417c4a77e3d645d1973,
    128'h60814fdc222a908846eeb814de5e0bdb,
    128'he0323a0a4906245cc2d3ac629195e479,
    128'he7c8376d8dd54ea96c56f4ea657aae08,
    128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
    128'h703eb5664803f60e613557b986c11d9e,
    128'he1f8981169d98e949b1e87e9ce5528df,
    128'h8ca1890dbfe6426841992d0fb054bb16
  };

  // single byte lookup
  function automatic logic [BYTE_W-1:0] sub_byte(input logic [BYTE_W-1:0] b);
    return SBOX[b];
  endfunction

  // ------------------------------
  // four parallel lookups
  // ------------------------------
  // byte order of the word is kept
  assign sub_word = {
    sub_byte(word[3*BYTE_W +: BYTE_W]),
    sub_byte(word[2*BYTE_W +: BYTE_W]),
    sub_byte(word[1*BYTE_W +: BYTE_W]),
    sub_byte(word[0*BYTE_W +: BYTE_W])
  };

endmodule

//--- hw/aes_round_ctrl.sv
/*
 * encipher control FSM: initial AddRoundKey, round counter,
 * key index, round issue and the result register
 */

`timescale 1ns/1ps

module aes_round_ctrl import aes_pkg::*; #(
  parameter int NUM_ROUNDS = 10
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 next,
  input  logic [BLOCK_W-1:0]   block,
  input  logic [BLOCK_W-1:0]   round_key,
  output logic [KEY_IDX_W-1:0] key_index,
  output logic [BLOCK_W-1:0]   result,
  output logic                 ready,
  aes_round_if.src             issue,
  input  logic                 out_valid,
  input  aes_state_t           out_state
);

  typedef enum logic [1:0] {
    CTRL_IDLE,
    CTRL_INIT,
    CTRL_RUN
  } ctrl_state_t;

  ctrl_state_t          ctrl_reg;
  aes_state_t           state_reg;
  logic                 issue_valid;
  logic                 issue_last;
  logic                 do_issue;
  logic [KEY_IDX_W-1:0] round_next;

  // ------------------------------
  // round issue
  // ------------------------------
  // round 1 right after init, later rounds when a non-final round returns
  assign round_next = key_index + KEY_IDX_W'(1);
  assign do_issue   = (ctrl_reg == CTRL_INIT) ||
                      ((ctrl_reg == CTRL_RUN) && out_valid && !issue_last);

  // key comes straight from the environment for the current index
  assign issue.valid     = issue_valid;
  assign issue.state     = state_reg;
  assign issue.last      = issue_last;
  assign issue.round_key = round_key;

  // ------------------------------
  // FSM, counter, result
  // ------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      ctrl_reg    <= CTRL_IDLE;
      key_index   <= '0;
      issue_valid <= 1'b0;
      issue_last  <= 1'b0;
      ready       <= 1'b1;
      result      <= '0;
    end
    else
    begin
      issue_valid <= do_issue;
      // last flag decided here only, travels with the round
      if (do_issue)
      begin
        key_index  <= round_next;
        issue_last <= (round_next == KEY_IDX_W'(NUM_ROUNDS));
      end
      case (ctrl_reg)
        CTRL_IDLE:
        begin
          if (next)
          begin
            ready    <= 1'b0;
            ctrl_reg <= CTRL_INIT;
          end
        end
        CTRL_INIT:
          ctrl_reg <= CTRL_RUN;
        CTRL_RUN:
        begin
          // final round back, back to key 0 for the next block
          if (out_valid && issue_last)
          begin
            result    <= out_state;
            ready     <= 1'b1;
            key_index <= '0;
            ctrl_reg  <= CTRL_IDLE;
          end
        end
        default:
          ctrl_reg <= CTRL_IDLE;
      endcase
    end
  end

  // initial AddRoundKey with key 0, then each returned round
  always_ff @(posedge clk)
  begin
    if ((ctrl_reg == CTRL_IDLE) && next)
      state_reg <= block ^ round_key;
    else if ((ctrl_reg == CTRL_RUN) && out_valid)
      state_reg <= out_state;
  end

  // ------------------------------
  // checks
  // ------------------------------
  key_index_range: assert property (@(posedge clk) disable iff (!reset_n)
    key_index <= KEY_IDX_W'(NUM_ROUNDS));

  // a round only comes back while one is in flight
  no_return_in_idle: assert property (@(posedge clk) disable iff (!reset_n)
    out_valid |-> (ctrl_reg != CTRL_IDLE));

endmodule

//--- hw/aes_sub_bytes.sv
/*
 * word-serial SubBytes stage, one column per clock,
 * column 0 substituted on the capture edge
 */

`timescale 1ns/1ps

module aes_sub_bytes import aes_pkg::*; (
  input  logic     clk,
  input  logic     reset_n,
  aes_round_if.dst in_rnd,
  aes_round_if.src out_rnd
);

  aes_state_t         state_reg;
  aes_state_t         state_base;
  aes_state_t         state_new;
  logic [BLOCK_W-1:0] key_reg;
  logic               last_reg;
  logic               valid_reg;
  // column being substituted, nonzero while busy
  logic [1:0]         word_ctr;
  logic [1:0]         word_sel;
  logic               busy;
  logic [WORD_W-1:0]  sbox_in;
  logic [WORD_W-1:0]  sbox_out;

  assign busy = (word_ctr != 2'd0);

  // ------------------------------
  // column select
  // ------------------------------
  // new item goes to the S-box directly, no idle cycle
  assign state_base = in_rnd.valid ? in_rnd.state : state_reg;
  assign word_sel   = in_rnd.valid ? 2'd0 : word_ctr;
  assign sbox_in    = state_base.cols[word_sel];

  aes_sbox aes_sbox_i (
    .word     (sbox_in),
    .sub_word (sbox_out)
  );

  // replace one column, keep the other three
  always_comb
  begin
    state_new                = state_base;
    state_new.cols[word_sel] = sbox_out;
  end

  // ------------------------------
  // counter and strobe
  // ------------------------------
  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      word_ctr  <= 2'd0;
      valid_reg <= 1'b0;
    end
    else
    begin
      // last column written on this edge, forward next cycle
      valid_reg <= busy && (word_ctr == 2'(NUM_COLS - 1));
      if (in_rnd.valid)
        word_ctr <= 2'd1;
      else if (busy)
        word_ctr <= word_ctr + 2'd1;
    end
  end

  // payload
  always_ff @(posedge clk)
  begin
    if (in_rnd.valid || busy)
      state_reg <= state_new;
    if (in_rnd.valid)
    begin
      key_reg  <= in_rnd.round_key;
      last_reg <= in_rnd.last;
    end
  end

  assign out_rnd.valid     = valid_reg;
  assign out_rnd.state     = state_reg;
  assign out_rnd.last      = last_reg;
  assign out_rnd.round_key = key_reg;

  // upstream must wait for the whole word loop
  no_overrun: assert property (@(posedge clk) disable iff (!reset_n)
    busy |-> !in_rnd.valid);

endmodule

//--- hw/aes_mix_add.sv
/*
 * ShiftRows, MixColumns (skipped in the final round) and
 * AddRoundKey, registered with a one-cycle done strobe
 */

`timescale 1ns/1ps

module aes_mix_add import aes_pkg::*; (
  input  logic       clk,
  input  logic       reset_n,
  aes_round_if.dst   in_rnd,
  output logic       out_valid,
  output aes_state_t out_state
);

  // bytes per column
  localparam int ROWS = WORD_W / BYTE_W;

  aes_state_t shifted;
  aes_state_t mixed;
  aes_state_t next_state;

  // ------------------------------
  // ShiftRows
  // ------------------------------
  // row r rotates left by r columns
  always_comb
  begin
    for (int c = 0; c < NUM_COLS; c++)
    begin
      for (int r = 0; r < ROWS; r++)
      begin
        shifted.bytes[ROWS*c + r] = in_rnd.state.bytes[ROWS*((c + r) % NUM_COLS) + r];
      end
    end
  end

  // ------------------------------
  // MixColumns
  // ------------------------------
  // fixed polynomial {03}x^3 + {01}x^2 + {01}x + {02}, per column
  always_comb
  begin
    for (int c = 0; c < NUM_COLS; c++)
    begin
      mixed.bytes[ROWS*c + 0] = gm2(shifted.bytes[ROWS*c + 0]) ^ gm3(shifted.bytes[ROWS*c + 1]) ^
                                shifted.bytes[ROWS*c + 2] ^ shifted.bytes[ROWS*c + 3];
      mixed.bytes[ROWS*c + 1] = shifted.bytes[ROWS*c + 0] ^ gm2(shifted.bytes[ROWS*c + 1]) ^
                                gm3(shifted.bytes[ROWS*c + 2]) ^ shifted.bytes[ROWS*c + 3];
      mixed.bytes[ROWS*c + 2] = shifted.bytes[ROWS*c + 0] ^ shifted.bytes[ROWS*c + 1] ^
                                gm2(shifted.bytes[ROWS*c + 2]) ^ gm3(shifted.bytes[ROWS*c + 3]);
      mixed.bytes[ROWS*c + 3] = gm3(shifted.bytes[ROWS*c + 0]) ^ shifted.bytes[ROWS*c + 1] ^
                                shifted.bytes[ROWS*c + 2] ^ gm2(shifted.bytes[ROWS*c + 3]);
    end
  end

  // ------------------------------
  // AddRoundKey and output
  // ------------------------------
  // final round bypasses the mix
  assign next_state = (in_rnd.last ? shifted : mixed) ^ in_rnd.round_key;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
      out_valid <= 1'b0;
    else
      out_valid <= in_rnd.valid;
  end

  always_ff @(posedge clk)
  begin
    if (in_rnd.valid)
      out_state <= next_state;
  end

  // rounds are at least four cycles apart after SubBytes
  single_strobe: assert property (@(posedge clk) disable iff (!reset_n)
    out_valid |=> !out_valid);

endmodule

//--- hw/aes_encipher_core.sv
/*
 * iterative AES encipher core: control, word-serial SubBytes
 * and the mix/add stage, round keys supplied from outside
 */

`timescale 1ns/1ps

module aes_encipher_core import aes_pkg::*; #(
  parameter int NUM_ROUNDS = 10
) (
  input  logic                 clk,
  input  logic                 reset_n,
  input  logic                 next,
  input  logic [BLOCK_W-1:0]   block,
  // must follow key_index in the same cycle
  input  logic [BLOCK_W-1:0]   round_key,
  output logic [KEY_IDX_W-1:0] key_index,
  output logic [BLOCK_W-1:0]   result,
  output logic                 ready
);

  // ------------------------------
  // stage links
  // ------------------------------
  // control to SubBytes
  aes_round_if issue_if ();
  // SubBytes to mix/add
  aes_round_if mix_if ();

  // mix/add back to control
  logic       out_valid;
  aes_state_t out_state;

  // ------------------------------
  // stages
  // ------------------------------
  aes_round_ctrl #(
    .NUM_ROUNDS (NUM_ROUNDS)
  ) aes_round_ctrl_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .next      (next),
    .block     (block),
    .round_key (round_key),
    .key_index (key_index),
    .result    (result),
    .ready     (ready),
    .issue     (issue_if.src),
    .out_valid (out_valid),
    .out_state (out_state)
  );

  aes_sub_bytes aes_sub_bytes_i (
    .clk     (clk),
    .reset_n (reset_n),
    .in_rnd  (issue_if.dst),
    .out_rnd (mix_if.src)
  );

  aes_mix_add aes_mix_add_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .in_rnd    (mix_if.dst),
    .out_valid (out_valid),
    .out_state (out_state)
  );

endmodule

//--- bench/tb_aes_encipher.sv
/*
 * testbench for the AES encipher core: trace-driven blocks, key memory
 * model, start-to-ready latency, stray start and result hold checks
 */

`timescale 1ns/1ps

module tb_aes_encipher import aes_pkg::*; ();

  localparam int NUM_ROUNDS   = 10;
  localparam int NUM_RECORDS  = 2;
  // plaintext, NUM_ROUNDS + 1 round keys, ciphertext
  localparam int REC_WORDS    = NUM_ROUNDS + 3;
  // 1 init edge, then 6 edges per round
  localparam int LATENCY      = 1 + 6 * NUM_ROUNDS;
  localparam int TIMEOUT      = 200;
  localparam int RESET_CYCLES = 16;

  logic                 clk;
  logic                 reset_n;
  logic                 next;
  logic [BLOCK_W-1:0]   block;
  logic [BLOCK_W-1:0]   round_key;
  logic [KEY_IDX_W-1:0] key_index;
  logic [BLOCK_W-1:0]   result;
  logic                 ready;

  logic [BLOCK_W-1:0] trace_mem [0:NUM_RECORDS*REC_WORDS-1];
  // record whose keys the key memory serves
  int   cur_rec;
  int   seed;
  int   gap;
  int   stray_at;
  int   test_count;
  int   fail_count;
  int   err_count;
  int   index_errors = 0;
  logic timed_out;

  // ------------------------------
  // DUT and key memory
  // ------------------------------
  aes_encipher_core #(
    .NUM_ROUNDS (NUM_ROUNDS)
  ) aes_encipher_core_i (
    .clk       (clk),
    .reset_n   (reset_n),
    .next      (next),
    .block     (block),
    .round_key (round_key),
    .key_index (key_index),
    .result    (result),
    .ready     (ready)
  );

  // same-cycle lookup by key_index
  assign round_key = trace_mem[cur_rec*REC_WORDS + 1 + int'(key_index)];

  initial clk = 1'b0;
  always #50 clk = ~clk;

  // key_index range, watched all the time
  always @(negedge clk)
  begin
    if (reset_n === 1'b1 && int'(key_index) > NUM_ROUNDS)
    begin
      $display("key_index went past %0d, now %0d", NUM_ROUNDS, key_index);
      index_errors++;
    end
  end

  // ------------------------------
  // helpers
  // ------------------------------
  function automatic logic [BLOCK_W-1:0] plaintext_of(input int rec);
    return trace_mem[rec*REC_WORDS];
  endfunction

  function automatic logic [BLOCK_W-1:0] ciphertext_of(input int rec);
    return trace_mem[rec*REC_WORDS + REC_WORDS - 1];
  endfunction

  // one line per finished test
  task automatic close_test(input string name);
    test_count++;
    if (err_count == 0)
      $display("test %0d %s: ok", test_count, name);
    else
    begin
      fail_count++;
      $display("test %0d %s: %0d error(s)", test_count, name, err_count);
    end
    err_count = 0;
  endtask

  // idle cycles, result must hold
  task automatic idle_gap(input int cycles);
    logic [BLOCK_W-1:0] held;
    held = result;
    for (int i = 0; i < cycles; i++)
    begin
      @(negedge clk);
      if (result !== held)
      begin
        $display("MISMATCH result: got %h expected %h", result, held);
        err_count++;
      end
    end
  endtask

  // one block start to finish, optional stray next at cycle stray_cyc
  task automatic run_block(input int rec, input int stray_cyc, input int stray_rec);
    int cnt;
    cnt = 0;
    @(posedge clk);
    cur_rec <= rec;
    block   <= plaintext_of(rec);
    next    <= 1'b1;
    // start edge
    @(posedge clk);
    next <= 1'b0;
    @(negedge clk);
    if (ready !== 1'b0)
    begin
      $display("ready did not fall on the start edge");
      err_count++;
    end
    while (ready !== 1'b1 && cnt < TIMEOUT)
    begin
      @(posedge clk);
      if (cnt == stray_cyc)
      begin
        block <= plaintext_of(stray_rec);
        next  <= 1'b1;
      end
      else
        next <= 1'b0;
      @(negedge clk);
      cnt++;
    end
    if (ready !== 1'b1)
    begin
      $display("ready never rose within %0d cycles", TIMEOUT);
      timed_out = 1'b1;
      err_count++;
    end
    else
    begin
      if (cnt != LATENCY)
      begin
        $display("ready rose %0d edges after start instead of %0d", cnt, LATENCY);
        err_count++;
      end
      if (result !== ciphertext_of(rec))
      begin
        $display("MISMATCH result: got %h expected %h", result, ciphertext_of(rec));
        err_count++;
      end
    end
  endtask

  // ------------------------------
  // test sequence
  // ------------------------------
  initial
  begin
    seed       = 32'hee7c;
    test_count = 0;
    fail_count = 0;
    err_count  = 0;
    timed_out  = 1'b0;
    cur_rec    = 0;
    reset_n    = 1'b0;
    next       = 1'b0;
    block      = '0;
    $readmemh("bench/aes_trace.hex", trace_mem);

    repeat (RESET_CYCLES) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);

    // values straight out of reset
    if (ready !== 1'b1)
    begin
      $display("MISMATCH ready: got %h expected %h", ready, 1'b1);
      err_count++;
    end
    if (key_index !== '0)
    begin
      $display("MISMATCH key_index: got %h expected %h", key_index, 4'h0);
      err_count++;
    end
    if (result !== '0)
    begin
      $display("MISMATCH result: got %h expected %h", result, {BLOCK_W{1'b0}});
      err_count++;
    end
    close_test("reset values");

    // every trace record, random idle gap first
    for (int rec = 0; rec < NUM_RECORDS; rec++)
    begin
      if (!timed_out)
      begin
        gap = $unsigned($random(seed)) % 6;
        idle_gap(gap);
        run_block(rec, -1, 0);
        close_test($sformatf("record %0d cipher and latency", rec));
      end
    end

    // second start while busy, other block on the bus
    if (!timed_out)
    begin
      gap      = $unsigned($random(seed)) % 6;
      stray_at = $unsigned($random(seed)) % 50;
      idle_gap(gap);
      run_block(0, stray_at, 1);
      close_test($sformatf("next ignored while busy, cycle %0d", stray_at));
    end

    // result hold after completion, index range over the whole run
    if (!timed_out)
    begin
      idle_gap(8);
      if (index_errors != 0)
        err_count += index_errors;
      close_test("result hold and key_index range");
    end

    $display("%0d tests run, %0d failed", test_count, fail_count);
    if (fail_count == 0 && !timed_out)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- bench/aes_trace.hex
// per record: plaintext, round keys 0..10, expected ciphertext
// 128-bit words, 13 per record; record 0 is the FIPS-197 appendix B example
3243f6a8885a308d313198a2e0370734 2b7e151628aed2a6abf7158809cf4f3c
a0fafe1788542cb123a339392a6c7605 f2c295f27a96b9435935807a7359f67f
3d80477d4716fe3e1e237e446d7a883b ef44a541a8525b7fb671253bdb0bad00
d4d1c6f87c839d87caf2b8bc11f915bc 6d88a37a110b3efddbf98641ca0093fd
4e54f70e5f5fc9f384a64fb24ea6dc4f ead27321b58dbad2312bf5607f8d292f
ac7766f319fadc2128d12941575c006e d014f9a8c9ee2589e13f0cc8b6630ca6
3925841d02dc09fbdc118597196a0b32
00112233445566778899aabbccddeeff 000102030405060708090a0b0c0d0e0f
d6aa74fdd2af72fadaa678f1d6ab76fe b692cf0b643dbdf1be9bc5006830b3fe
b6ff744ed2c2c9bf6c590cbf0469bf41 47f7f7bc95353e03f96c32bcfd058dfd
3caaa3e8a99f9deb50f3af57adf622aa 5e390f7df7a69296a7553dc10aa31f6b
14f9701ae35fe28c440adf4d4ea9c026 47438735a41c65b9e016baf4aebf7ad2
549932d1f08557681093ed9cbe2c974e 13111d7fe3944a17f307a78b4d2b30c5
69c4e0d86a7b0430d8cdb78070b4c55a

//--- vlog.f
hw/aes_pkg.sv
hw/aes_round_if.sv
hw/aes_sbox.sv
hw/aes_round_ctrl.sv
hw/aes_sub_bytes.sv
hw/aes_mix_add.sv
hw/aes_encipher_core.sv
bench/tb_aes_encipher.sv

//--- Makefile
# Verilator build and run for the AES encipher core testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       ?= tb_aes_encipher
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
